// ==== verilog.f ====
design/lsrs_pkg.sv
design/lsrs_addr_queue.sv
design/lsrs_load_station.sv
design/lsrs_store_station.sv
design/lsrs_mem_issue.sv
design/lsrs_top.sv
test/lsrs_tb.sv

// ==== Bender.yml ====
package:
  name: lsrs

sources:
  - design/lsrs_pkg.sv
  - design/lsrs_addr_queue.sv
  - design/lsrs_load_station.sv
  - design/lsrs_store_station.sv
  - design/lsrs_mem_issue.sv
  - design/lsrs_top.sv
  - target: simulation
    files:
      - test/lsrs_tb.sv

// ==== test/lsrs_tb.sv ====
module lsrs_tb;

	localparam int TIMEOUT_CYCLES = 400; // about four times the summed test lengths

	logic clk = 1'b0;
	logic rst_n;
	logic i_iq_valid;
	lsrs_pkg::iq_req_t i_iq;
	lsrs_pkg::cdb_t i_cdb;
	logic i_mu_ready;
	logic o_iq_ready;
	logic o_mu_valid;
	lsrs_pkg::mu_req_t o_mu;
	int cycles = 0;

	lsrs_top lsrs_top_inst (
		.clk(clk), .rst_n(rst_n), .i_iq_valid(i_iq_valid), .i_iq(i_iq), .i_cdb(i_cdb),
		.i_mu_ready(i_mu_ready), .o_iq_ready(o_iq_ready), .o_mu_valid(o_mu_valid), .o_mu(o_mu)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			stop_with_failure();
		end
	end

	task automatic stop_with_failure();
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error: %s is %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	// base plus sign-extended immediate
	function automatic lsrs_pkg::data_t effective_addr(input lsrs_pkg::data_t base,
		input logic [lsrs_pkg::IMM_W-1:0] imm);
		return base + {{(lsrs_pkg::DATA_W-lsrs_pkg::IMM_W){imm[lsrs_pkg::IMM_W-1]}}, imm};
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic dispatch(input lsrs_pkg::tag_t tag, input logic is_store,
		input lsrs_pkg::operand_t base, input lsrs_pkg::operand_t data,
		input logic [lsrs_pkg::IMM_W-1:0] imm);
		i_iq_valid = 1'b1;
		i_iq.tag = tag;
		i_iq.is_store = is_store;
		i_iq.base = base;
		i_iq.data = data;
		i_iq.imm = imm;
		@(negedge clk);
		while (!o_iq_ready) @(negedge clk);
		next_cycle(); // accepted at this edge
		i_iq_valid = 1'b0;
	endtask

	task automatic broadcast(input lsrs_pkg::tag_t tag, input lsrs_pkg::data_t data);
		i_cdb.valid = 1'b1;
		i_cdb.tag = tag;
		i_cdb.data = data;
		next_cycle();
		i_cdb.valid = 1'b0;
	endtask

	// waits for the next offer and lets it go through
	task automatic expect_issue(input lsrs_pkg::tag_t tag, input logic is_store,
		input lsrs_pkg::data_t addr, input lsrs_pkg::data_t wdata);
		@(negedge clk);
		while (!o_mu_valid) @(negedge clk);
		check_value("o_mu.tag", 32'(o_mu.tag), 32'(tag));
		check_value("o_mu.is_store", 32'(o_mu.is_store), 32'(is_store));
		check_value("o_mu.addr", o_mu.addr, addr);
		if (is_store) begin
			check_value("o_mu.wdata", o_mu.wdata, wdata);
		end
		next_cycle();
	endtask

	task automatic expect_no_issue(input int n);
		repeat (n) begin
			@(negedge clk);
			check_value("o_mu_valid", 32'(o_mu_valid), 32'd0);
			next_cycle();
		end
	endtask

	task automatic load_address();
		lsrs_pkg::data_t base;
		logic [lsrs_pkg::IMM_W-1:0] imm;
		base = $urandom;
		imm = lsrs_pkg::IMM_W'($urandom) | 12'h800; // negative offset
		dispatch(4'd1, 1'b0, {4'd0, base}, '0, imm);
		expect_issue(4'd1, 1'b0, effective_addr(base, imm), '0);
		expect_no_issue(3);
	endtask

	task automatic store_data_from_cdb();
		lsrs_pkg::data_t addr;
		lsrs_pkg::data_t data;
		addr = $urandom;
		data = $urandom;
		dispatch(4'd2, 1'b1, {4'd0, addr}, {4'd5, 32'hdead_beef}, '0);
		expect_no_issue(4);
		broadcast(4'd5, data);
		expect_issue(4'd2, 1'b1, addr, data);
	endtask

	task automatic same_address_order();
		lsrs_pkg::data_t addr_a;
		lsrs_pkg::data_t addr_b;
		lsrs_pkg::data_t data;
		addr_a = $urandom;
		addr_b = addr_a ^ 32'h40;
		data = $urandom;
		dispatch(4'd3, 1'b1, {4'd0, addr_a - 32'd8}, {4'd6, 32'h0}, 12'd8); // lands on addr_a
		dispatch(4'd4, 1'b0, {4'd0, addr_a}, '0, '0);
		dispatch(4'd5, 1'b0, {4'd0, addr_b}, '0, '0);
		expect_issue(4'd5, 1'b0, addr_b, '0);
		expect_no_issue(2); // load 4 still held behind the store
		broadcast(4'd6, data);
		expect_issue(4'd3, 1'b1, addr_a, data);
		expect_issue(4'd4, 1'b0, addr_a, '0);
	endtask

	task automatic base_from_cdb();
		lsrs_pkg::data_t base;
		logic [lsrs_pkg::IMM_W-1:0] imm;
		base = $urandom;
		imm = lsrs_pkg::IMM_W'($urandom);
		dispatch(4'd7, 1'b0, {4'd8, 32'h0bad_0bad}, '0, imm);
		expect_no_issue(3);
		broadcast(4'd8, base);
		expect_issue(4'd7, 1'b0, effective_addr(base, imm), '0);
	endtask

	task automatic backpressure_full_station();
		lsrs_pkg::data_t addr [lsrs_pkg::N_LOAD];
		lsrs_pkg::data_t st_addr;
		lsrs_pkg::data_t st_data;
		lsrs_pkg::mu_req_t held;
		logic [lsrs_pkg::N_LOAD-1:0] seen;
		int k;
		i_mu_ready = 1'b0;
		seen = '0;
		for (int i = 0; i < lsrs_pkg::N_LOAD; i++) begin
			addr[i] = ($urandom & 32'hffff_ff00) | (i << 2);
			dispatch(lsrs_pkg::TAG_W'(9 + i), 1'b0, {4'd0, addr[i]}, '0, '0);
		end
		st_addr = addr[0] | 32'h80; // matches no load
		st_data = $urandom;
		i_iq_valid = 1'b1;
		i_iq.is_store = 1'b0;
		i_iq.tag = 4'd14;
		@(negedge clk);
		check_value("o_iq_ready", 32'(o_iq_ready), 32'd0);
		next_cycle();
		dispatch(4'd13, 1'b1, {4'd0, st_addr}, {4'd0, st_data}, '0);
		@(negedge clk);
		while (!o_mu_valid) @(negedge clk);
		held = o_mu;
		repeat (4) begin
			@(negedge clk);
			check_value("o_mu_valid", 32'(o_mu_valid), 32'd1);
			assert (o_mu === held) else begin
				$display("Error: o_mu is %h, expected %h while stalled", o_mu, held);
				stop_with_failure();
			end
		end
		next_cycle();
		i_mu_ready = 1'b1;
		repeat (lsrs_pkg::N_LOAD) begin
			@(negedge clk);
			while (!o_mu_valid) @(negedge clk);
			check_value("o_mu.is_store", 32'(o_mu.is_store), 32'd0);
			k = int'(o_mu.tag) - 9;
			assert (k >= 0 && k < lsrs_pkg::N_LOAD && !seen[k]) else begin
				$display("Load with tag %h was unexpected or issued more than once", o_mu.tag);
				stop_with_failure();
			end
			seen[k] = 1'b1;
			check_value("o_mu.addr", o_mu.addr, addr[k]);
			next_cycle();
		end
		expect_issue(4'd13, 1'b1, st_addr, st_data);
		expect_no_issue(3);
	endtask

	initial begin
		void'($urandom(32'h54ef));
		rst_n = 1'b0;
		i_iq_valid = 1'b0;
		i_iq = '0;
		i_cdb = '0;
		i_mu_ready = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		i_mu_ready = 1'b1;
		next_cycle();
		load_address();
		store_data_from_cdb();
		same_address_order();
		base_from_cdb();
		backpressure_full_station();
		$display("No errors");
		$finish;
	end

endmodule

// ==== design/lsrs_top.sv ====
module lsrs_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_iq_valid,
	input  lsrs_pkg::iq_req_t   i_iq,
	input  lsrs_pkg::cdb_t      i_cdb,
	input  logic                i_mu_ready,
	output logic                o_iq_ready,
	output logic                o_mu_valid,
	output lsrs_pkg::mu_req_t   o_mu
);

	logic aq_full;
	logic ld_full;
	logic st_full;
	logic push;
	lsrs_pkg::aq_write_t aq_write;
	lsrs_pkg::ld_view_t ld_view;
	lsrs_pkg::st_view_t st_view;
	logic [lsrs_pkg::SLOT_W-1:0] ld_free;
	logic [lsrs_pkg::SLOT_W-1:0] st_free;
	logic [lsrs_pkg::N_LOAD-1:0] ld_ready;
	logic [lsrs_pkg::N_LOAD-1:0] grant_ld;
	lsrs_pkg::tag_t [lsrs_pkg::N_LOAD-1:0] ld_tag;
	lsrs_pkg::data_t [lsrs_pkg::N_LOAD-1:0] ld_addr;
	logic [lsrs_pkg::N_STORE-1:0] st_ready;
	logic [lsrs_pkg::N_STORE-1:0] grant_st;
	lsrs_pkg::tag_t [lsrs_pkg::N_STORE-1:0] st_tag;
	lsrs_pkg::data_t [lsrs_pkg::N_STORE-1:0] st_addr;
	lsrs_pkg::data_t [lsrs_pkg::N_STORE-1:0] st_wdata;

	// need room in the queue and in the station of the instruction's kind
	assign o_iq_ready = !aq_full && (i_iq.is_store ? !st_full : !ld_full);
	assign push = i_iq_valid && o_iq_ready;

	lsrs_addr_queue addr_queue_inst (
		.clk(clk), .rst_n(rst_n),
		.i_push(push), .i_push_base(i_iq.base), .i_push_imm(i_iq.imm),
		.i_push_is_store(i_iq.is_store), .i_push_slot(i_iq.is_store ? st_free : ld_free),
		.i_cdb(i_cdb), .o_full(aq_full), .o_write(aq_write)
	);

	lsrs_load_station load_station_inst (
		.clk(clk), .rst_n(rst_n),
		.i_alloc(push && !i_iq.is_store), .i_alloc_tag(i_iq.tag),
		.i_write(aq_write), .i_st_view(st_view),
		.i_grant_ld(grant_ld), .i_grant_st(grant_st),
		.o_free_slot(ld_free), .o_full(ld_full), .o_ready(ld_ready),
		.o_tag(ld_tag), .o_addr(ld_addr), .o_view(ld_view)
	);

	lsrs_store_station store_station_inst (
		.clk(clk), .rst_n(rst_n),
		.i_alloc(push && i_iq.is_store), .i_alloc_tag(i_iq.tag), .i_alloc_data(i_iq.data),
		.i_cdb(i_cdb), .i_write(aq_write), .i_ld_view(ld_view),
		.i_grant_ld(grant_ld), .i_grant_st(grant_st),
		.o_free_slot(st_free), .o_full(st_full), .o_ready(st_ready),
		.o_tag(st_tag), .o_addr(st_addr), .o_wdata(st_wdata), .o_view(st_view)
	);

	lsrs_mem_issue mem_issue_inst (
		.clk(clk), .rst_n(rst_n),
		.i_ld_ready(ld_ready), .i_ld_tag(ld_tag), .i_ld_addr(ld_addr),
		.i_st_ready(st_ready), .i_st_tag(st_tag), .i_st_addr(st_addr),
		.i_st_wdata(st_wdata), .i_mu_ready(i_mu_ready),
		.o_grant_ld(grant_ld), .o_grant_st(grant_st),
		.o_mu_valid(o_mu_valid), .o_mu(o_mu)
	);

endmodule

// ==== design/lsrs_mem_issue.sv ====
module lsrs_mem_issue (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic [lsrs_pkg::N_LOAD-1:0]                i_ld_ready,
	input  lsrs_pkg::tag_t [lsrs_pkg::N_LOAD-1:0]      i_ld_tag,
	input  lsrs_pkg::data_t [lsrs_pkg::N_LOAD-1:0]     i_ld_addr,
	input  logic [lsrs_pkg::N_STORE-1:0]               i_st_ready,
	input  lsrs_pkg::tag_t [lsrs_pkg::N_STORE-1:0]     i_st_tag,
	input  lsrs_pkg::data_t [lsrs_pkg::N_STORE-1:0]    i_st_addr,
	input  lsrs_pkg::data_t [lsrs_pkg::N_STORE-1:0]    i_st_wdata,
	input  logic                                       i_mu_ready,
	output logic [lsrs_pkg::N_LOAD-1:0]                o_grant_ld,
	output logic [lsrs_pkg::N_STORE-1:0]               o_grant_st,
	output logic                                       o_mu_valid,
	output lsrs_pkg::mu_req_t                          o_mu
);

	logic [lsrs_pkg::SLOT_W-1:0] ld_ptr;
	logic [lsrs_pkg::SLOT_W-1:0] st_ptr;
	logic [lsrs_pkg::SLOT_W-1:0] ld_pick;
	logic [lsrs_pkg::SLOT_W-1:0] st_pick;
	logic [lsrs_pkg::SLOT_W-1:0] sel_idx;
	logic [lsrs_pkg::SLOT_W-1:0] lock_idx;
	logic sel_st;
	logic lock_valid;
	logic lock_st;
	logic hs;

	// first requester at or after ptr, wrapping at n
	function automatic logic [lsrs_pkg::SLOT_W-1:0] rr_pick(
		input logic [lsrs_pkg::N_MAX-1:0] req,
		input logic [lsrs_pkg::SLOT_W-1:0] ptr,
		input int n
	);
		int idx;
		logic found;
		rr_pick = ptr;
		found = 1'b0;
		for (int k = 0; k < n; k++) begin
			idx = (int'(ptr) + k) % n;
			if (!found && req[idx]) begin
				rr_pick = lsrs_pkg::SLOT_W'(idx);
				found = 1'b1;
			end
		end
	endfunction

	assign ld_pick = rr_pick(lsrs_pkg::N_MAX'(i_ld_ready), ld_ptr, lsrs_pkg::N_LOAD);
	assign st_pick = rr_pick(lsrs_pkg::N_MAX'(i_st_ready), st_ptr, lsrs_pkg::N_STORE);

	// a stalled offer stays put until the memory unit takes it
	always_comb begin
		if (lock_valid) begin
			sel_st = lock_st;
			sel_idx = lock_idx;
		end else if (|i_ld_ready) begin
			sel_st = 1'b0; // loads first
			sel_idx = ld_pick;
		end else begin
			sel_st = 1'b1;
			sel_idx = st_pick;
		end
		o_mu_valid = lock_valid || (|i_ld_ready) || (|i_st_ready);
		o_mu.is_store = sel_st;
		o_mu.tag = sel_st ? i_st_tag[sel_idx] : i_ld_tag[sel_idx];
		o_mu.addr = sel_st ? i_st_addr[sel_idx] : i_ld_addr[sel_idx];
		o_mu.wdata = sel_st ? i_st_wdata[sel_idx] : '0;
	end

	assign hs = o_mu_valid && i_mu_ready;
	assign o_grant_ld = (hs && !sel_st) ? lsrs_pkg::N_LOAD'(1) << sel_idx : '0;
	assign o_grant_st = (hs && sel_st) ? lsrs_pkg::N_STORE'(1) << sel_idx : '0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_ptr <= '0;
			st_ptr <= '0;
			lock_valid <= 1'b0;
			lock_st <= 1'b0;
			lock_idx <= '0;
		end else begin
			lock_valid <= o_mu_valid && !i_mu_ready;
			lock_st <= sel_st;
			lock_idx <= sel_idx;
			if (hs && !sel_st) begin
				ld_ptr <= lsrs_pkg::SLOT_W'((int'(sel_idx) + 1) % lsrs_pkg::N_LOAD);
			end
			if (hs && sel_st) begin
				st_ptr <= lsrs_pkg::SLOT_W'((int'(sel_idx) + 1) % lsrs_pkg::N_STORE);
			end
		end
	end

	a_hold: assert property (@(posedge clk) disable iff (!rst_n)
		o_mu_valid && !i_mu_ready |=> o_mu_valid && $stable(o_mu));
	a_st_grant_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(o_grant_st & ~i_st_ready) == '0);

endmodule

// ==== design/lsrs_store_station.sv ====
module lsrs_store_station (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic                                       i_alloc,
	input  lsrs_pkg::tag_t                             i_alloc_tag,
	input  lsrs_pkg::operand_t                         i_alloc_data,
	input  lsrs_pkg::cdb_t                             i_cdb,
	input  lsrs_pkg::aq_write_t                        i_write,
	input  lsrs_pkg::ld_view_t                         i_ld_view,
	input  logic [lsrs_pkg::N_LOAD-1:0]                i_grant_ld,
	input  logic [lsrs_pkg::N_STORE-1:0]               i_grant_st,
	output logic [lsrs_pkg::SLOT_W-1:0]                o_free_slot,
	output logic                                       o_full,
	output logic [lsrs_pkg::N_STORE-1:0]               o_ready,
	output lsrs_pkg::tag_t [lsrs_pkg::N_STORE-1:0]     o_tag,
	output lsrs_pkg::data_t [lsrs_pkg::N_STORE-1:0]    o_addr,
	output lsrs_pkg::data_t [lsrs_pkg::N_STORE-1:0]    o_wdata,
	output lsrs_pkg::st_view_t                         o_view
);

	logic [lsrs_pkg::N_STORE-1:0] valid;
	logic [lsrs_pkg::N_STORE-1:0] addr_valid;
	lsrs_pkg::tag_t [lsrs_pkg::N_STORE-1:0] data_tag;
	logic [lsrs_pkg::N_STORE-1:0][lsrs_pkg::N_LOAD-1:0] ld_dep;
	logic [lsrs_pkg::N_STORE-1:0][lsrs_pkg::N_STORE-1:0] st_dep;
	logic [lsrs_pkg::N_LOAD-1:0] ld_match;
	logic [lsrs_pkg::N_STORE-1:0] st_match;
	logic [lsrs_pkg::N_STORE-1:0] alloc_vec;
	logic [lsrs_pkg::N_STORE-1:0] wr_vec;
	logic [lsrs_pkg::N_STORE-1:0] cdb_hit;
	lsrs_pkg::operand_t alloc_data;

	always_comb begin
		o_free_slot = '0;
		for (int i = lsrs_pkg::N_STORE-1; i >= 0; i--) begin
			if (!valid[i]) begin
				o_free_slot = lsrs_pkg::SLOT_W'(i);
			end
		end
	end

	always_comb begin
		alloc_data = i_alloc_data;
		if (i_cdb.valid && i_alloc_data.tag != '0 && i_alloc_data.tag == i_cdb.tag) begin
			alloc_data.tag = '0;
			alloc_data.value = i_cdb.data;
		end
		for (int i = 0; i < lsrs_pkg::N_STORE; i++) begin
			alloc_vec[i] = i_alloc && (o_free_slot == lsrs_pkg::SLOT_W'(i));
			wr_vec[i] = i_write.valid && i_write.is_store
				&& (i_write.slot == lsrs_pkg::SLOT_W'(i));
			cdb_hit[i] = i_cdb.valid && data_tag[i] != '0 && data_tag[i] == i_cdb.tag;
			st_match[i] = addr_valid[i] && (o_addr[i] == i_write.addr) && !i_grant_st[i];
			o_ready[i] = valid[i] && addr_valid[i] && (ld_dep[i] == '0)
				&& (st_dep[i] == '0) && (data_tag[i] == '0);
		end
		for (int j = 0; j < lsrs_pkg::N_LOAD; j++) begin
			ld_match[j] = i_ld_view.addr_valid[j] && (i_ld_view.addr[j] == i_write.addr)
				&& !i_grant_ld[j];
		end
	end

	assign o_full = &valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			addr_valid <= '0;
			data_tag <= '0;
			ld_dep <= '0;
			st_dep <= '0;
		end else begin
			for (int i = 0; i < lsrs_pkg::N_STORE; i++) begin
				if (alloc_vec[i]) begin
					valid[i] <= 1'b1;
					addr_valid[i] <= 1'b0;
					ld_dep[i] <= '0;
					st_dep[i] <= '0;
				end else if (i_grant_st[i]) begin
					valid[i] <= 1'b0;
					addr_valid[i] <= 1'b0;
				end else if (wr_vec[i]) begin
					addr_valid[i] <= 1'b1; // own bit is clear here, no self dependency
					ld_dep[i] <= ld_match;
					st_dep[i] <= st_match;
				end else begin
					ld_dep[i] <= ld_dep[i] & ~i_grant_ld;
					st_dep[i] <= st_dep[i] & ~i_grant_st;
				end
				if (alloc_vec[i]) begin
					data_tag[i] <= alloc_data.tag;
				end else if (cdb_hit[i]) begin
					data_tag[i] <= '0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < lsrs_pkg::N_STORE; i++) begin
			if (alloc_vec[i]) begin
				o_tag[i] <= i_alloc_tag;
				o_wdata[i] <= alloc_data.value;
			end else if (cdb_hit[i]) begin
				o_wdata[i] <= i_cdb.data;
			end
			if (wr_vec[i]) begin
				o_addr[i] <= i_write.addr;
			end
		end
	end

	assign o_view.addr_valid = addr_valid;
	assign o_view.addr = o_addr;

	a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
		(alloc_vec & valid) == '0);

endmodule

// ==== design/lsrs_load_station.sv ====
module lsrs_load_station (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  logic                                       i_alloc,
	input  lsrs_pkg::tag_t                             i_alloc_tag,
	input  lsrs_pkg::aq_write_t                        i_write,
	input  lsrs_pkg::st_view_t                         i_st_view,
	input  logic [lsrs_pkg::N_LOAD-1:0]                i_grant_ld,
	input  logic [lsrs_pkg::N_STORE-1:0]               i_grant_st,
	output logic [lsrs_pkg::SLOT_W-1:0]                o_free_slot,
	output logic                                       o_full,
	output logic [lsrs_pkg::N_LOAD-1:0]                o_ready,
	output lsrs_pkg::tag_t [lsrs_pkg::N_LOAD-1:0]      o_tag,
	output lsrs_pkg::data_t [lsrs_pkg::N_LOAD-1:0]     o_addr,
	output lsrs_pkg::ld_view_t                         o_view
);

	logic [lsrs_pkg::N_LOAD-1:0] valid;
	logic [lsrs_pkg::N_LOAD-1:0] addr_valid;
	logic [lsrs_pkg::N_LOAD-1:0][lsrs_pkg::N_STORE-1:0] st_dep;
	logic [lsrs_pkg::N_STORE-1:0] st_match;
	logic wr_en;

	// lowest free slot
	always_comb begin
		o_free_slot = '0;
		for (int i = lsrs_pkg::N_LOAD-1; i >= 0; i--) begin
			if (!valid[i]) begin
				o_free_slot = lsrs_pkg::SLOT_W'(i);
			end
		end
	end

	// stores holding the same address, except one leaving this cycle
	always_comb begin
		for (int j = 0; j < lsrs_pkg::N_STORE; j++) begin
			st_match[j] = i_st_view.addr_valid[j] && (i_st_view.addr[j] == i_write.addr)
				&& !i_grant_st[j];
		end
	end

	assign wr_en = i_write.valid && !i_write.is_store;
	assign o_full = &valid;

	always_comb begin
		for (int i = 0; i < lsrs_pkg::N_LOAD; i++) begin
			o_ready[i] = valid[i] && addr_valid[i] && (st_dep[i] == '0);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= '0;
			addr_valid <= '0;
			st_dep <= '0;
		end else begin
			for (int i = 0; i < lsrs_pkg::N_LOAD; i++) begin
				if (i_alloc && o_free_slot == lsrs_pkg::SLOT_W'(i)) begin
					valid[i] <= 1'b1;
					addr_valid[i] <= 1'b0;
					st_dep[i] <= '0;
				end else if (i_grant_ld[i]) begin
					valid[i] <= 1'b0; // issued, slot free again
					addr_valid[i] <= 1'b0;
				end else if (wr_en && i_write.slot == lsrs_pkg::SLOT_W'(i)) begin
					addr_valid[i] <= 1'b1;
					st_dep[i] <= st_match;
				end else begin
					st_dep[i] <= st_dep[i] & ~i_grant_st;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < lsrs_pkg::N_LOAD; i++) begin
			if (i_alloc && o_free_slot == lsrs_pkg::SLOT_W'(i)) begin
				o_tag[i] <= i_alloc_tag;
			end
			if (wr_en && i_write.slot == lsrs_pkg::SLOT_W'(i)) begin
				o_addr[i] <= i_write.addr;
			end
		end
	end

	assign o_view.addr_valid = addr_valid;
	assign o_view.addr = o_addr;

	a_grant_ready: assert property (@(posedge clk) disable iff (!rst_n)
		(i_grant_ld & ~o_ready) == '0);

endmodule

// ==== design/lsrs_addr_queue.sv ====
module lsrs_addr_queue (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        i_push,
	input  lsrs_pkg::operand_t          i_push_base,
	input  logic [lsrs_pkg::IMM_W-1:0]  i_push_imm,
	input  logic                        i_push_is_store,
	input  logic [lsrs_pkg::SLOT_W-1:0] i_push_slot,
	input  lsrs_pkg::cdb_t              i_cdb,
	output logic                        o_full,
	output lsrs_pkg::aq_write_t         o_write
);

	lsrs_pkg::operand_t [lsrs_pkg::AQ_DEPTH-1:0] base;
	logic [lsrs_pkg::AQ_DEPTH-1:0][lsrs_pkg::IMM_W-1:0] imm;
	logic [lsrs_pkg::AQ_DEPTH-1:0] is_store;
	logic [lsrs_pkg::AQ_DEPTH-1:0][lsrs_pkg::SLOT_W-1:0] slot;
	logic [lsrs_pkg::AQ_PTR_W-1:0] head;
	logic [lsrs_pkg::AQ_PTR_W-1:0] tail;
	logic [lsrs_pkg::AQ_PTR_W:0] count;
	lsrs_pkg::operand_t push_base;
	lsrs_pkg::data_t imm_ext;
	logic pop;

	// a base that is broadcast in the push cycle is taken right away
	always_comb begin
		push_base = i_push_base;
		if (i_cdb.valid && i_push_base.tag != '0 && i_push_base.tag == i_cdb.tag) begin
			push_base.tag = '0;
			push_base.value = i_cdb.data;
		end
	end

	assign pop = (count != '0) && (base[head].tag == '0); // head base resolved
	assign imm_ext = lsrs_pkg::data_t'(signed'(imm[head]));
	assign o_full = (count == lsrs_pkg::AQ_DEPTH);

	always_comb begin
		o_write.valid = pop;
		o_write.is_store = is_store[head];
		o_write.slot = slot[head];
		o_write.addr = base[head].value + imm_ext;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (i_push) begin
				tail <= tail + 1'b1; // depth is a power of two, wraps
			end
			if (pop) begin
				head <= head + 1'b1;
			end
			case ({i_push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < lsrs_pkg::AQ_DEPTH; k++) begin
			if (i_push && tail == lsrs_pkg::AQ_PTR_W'(k)) begin
				base[k] <= push_base;
				imm[k] <= i_push_imm;
				is_store[k] <= i_push_is_store;
				slot[k] <= i_push_slot;
			end else if (i_cdb.valid && base[k].tag != '0 && base[k].tag == i_cdb.tag) begin
				base[k].tag <= '0; // snoop the CDB
				base[k].value <= i_cdb.data;
			end
		end
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
		i_push |-> !o_full);

endmodule

// ==== design/lsrs_pkg.sv ====
package lsrs_pkg;

	localparam int DATA_W   = 32;
	localparam int TAG_W    = 4; // tag 0 means the value is present
	localparam int IMM_W    = 12;
	localparam int N_LOAD   = 4;
	localparam int N_STORE  = 4;
	localparam int AQ_DEPTH = 8;
	localparam int N_MAX    = (N_LOAD > N_STORE) ? N_LOAD : N_STORE;
	localparam int SLOT_W   = $clog2(N_MAX);
	localparam int AQ_PTR_W = $clog2(AQ_DEPTH);

	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [DATA_W-1:0] data_t;

	typedef struct packed {
		tag_t  tag;
		data_t value;
	} operand_t;

	typedef struct packed {
		tag_t                   tag;
		operand_t               base;
		operand_t               data; // store data, unused by loads
		logic [IMM_W-1:0]       imm;
		logic                   is_store;
	} iq_req_t;

	typedef struct packed {
		logic  valid;
		tag_t  tag;
		data_t data;
	} cdb_t;

	// queue head on its way into a station
	typedef struct packed {
		logic              valid;
		logic              is_store;
		logic [SLOT_W-1:0] slot;
		data_t             addr;
	} aq_write_t;

	typedef struct packed {
		logic [N_LOAD-1:0]  addr_valid;
		data_t [N_LOAD-1:0] addr;
	} ld_view_t;

	typedef struct packed {
		logic [N_STORE-1:0]  addr_valid;
		data_t [N_STORE-1:0] addr;
	} st_view_t;

	typedef struct packed {
		tag_t  tag;
		logic  is_store;
		data_t addr;
		data_t wdata;
	} mu_req_t;

endpackage
